// File: source/fm_pkg.sv
package fm_pkg;

    localparam int HALF_CELL_CLKS = 4;  // Clocks per FM half-cell
    localparam int HALF_CELL_W    = 2;  // Width of the half-cell timer

    // Address marks, clock/data interleaved with some clock bits missing
    localparam logic [15:0] MARK_F8 = 16'b1111010101101010;
    localparam logic [15:0] MARK_FB = 16'b1111010101101111;
    localparam logic [15:0] MARK_FC = 16'b1111011101111010;
    localparam logic [15:0] MARK_FE = 16'b1111010101111110;

    localparam logic [1:0] MARK_SEL_F8 = 2'd0;
    localparam logic [1:0] MARK_SEL_FB = 2'd1;
    localparam logic [1:0] MARK_SEL_FC = 2'd2;
    localparam logic [1:0] MARK_SEL_FE = 2'd3;

    typedef struct packed {
        logic       is_mark;            // Always 0 in this view
        logic [7:0] data;
    } tx_data_view_t;

    typedef struct packed {
        logic       is_mark;            // Always 1 in this view
        logic [5:0] unused;
        logic [1:0] sel;
    } tx_mark_view_t;

    typedef union packed {
        tx_data_view_t data_view;
        tx_mark_view_t mark_view;
    } tx_entry_u;

endpackage

// File: source/fdc_regs_pkg.sv
package fdc_regs_pkg;

    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] REG_DATA   = 4'h0;
    localparam logic [APB_ADDR_W-1:0] REG_MARK   = 4'h4;
    localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 4'h8;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'hC;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_BREAK_BIT  = 1;  // Self clearing, reads back 0

    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_LEVEL_W = 4;     // Holds 0..FIFO_DEPTH
    localparam int FIFO_PTR_W   = 3;

endpackage

// File: source/tx_fifo_if.sv
`timescale 1ns/1ps

interface tx_fifo_if
    import fm_pkg::*;
    import fdc_regs_pkg::*;
();

    logic                    push;
    tx_entry_u               push_entry;
    logic                    full;
    logic                    pop;
    tx_entry_u               pop_entry;  // Head of queue, valid while !empty
    logic                    empty;
    logic [FIFO_LEVEL_W-1:0] level;
    logic                    flush;

    modport push_side (
        output push, push_entry, flush,
        input  full, empty, level
    );

    modport pop_side (
        output pop,
        input  pop_entry, empty, flush
    );

    modport fifo_side (
        input  push, push_entry, pop, flush,
        output full, empty, level, pop_entry
    );

endinterface

// File: source/tx_fifo.sv
`timescale 1ns/1ps

module tx_fifo
    import fm_pkg::*;
    import fdc_regs_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    tx_fifo_if.fifo_side  q
);

    tx_entry_u             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  push_ok;
    logic                  pop_ok;

    assign q.full  = (q.level == FIFO_LEVEL_W'(FIFO_DEPTH));
    assign q.empty = (q.level == '0);

    assign push_ok = q.push & ~q.full;
    assign pop_ok  = q.pop & ~q.empty;

    assign q.pop_entry = mem[rd_ptr];  // Fall-through head

    always_ff @(posedge clk) begin
        if (push_ok && !q.flush) begin
            mem[wr_ptr] <= q.push_entry;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q.level <= '0;
        end else if (q.flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q.level <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   q.level <= q.level + 1'b1;
                2'b01:   q.level <= q.level - 1'b1;
                default: q.level <= q.level;
            endcase
        end
    end

endmodule

// File: source/fdc_apb_regs.sv
`timescale 1ns/1ps

module fdc_apb_regs
    import fm_pkg::*;
    import fdc_regs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    input  logic                  tx_end,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  enable,
    tx_fifo_if.push_side          fifo
);

    logic      access;
    logic      wr_access;
    logic      push_addr;
    tx_entry_u entry;

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign push_addr = (paddr == REG_DATA) || (paddr == REG_MARK);
    assign pready    = 1'b1;  // Zero wait states

    // Same word, two encodings depending on the target register
    always_comb begin
        entry = '0;
        if (paddr == REG_MARK) begin
            entry.mark_view.is_mark = 1'b1;
            entry.mark_view.unused  = '0;
            entry.mark_view.sel     = pwdata[1:0];
        end else begin
            entry.data_view.is_mark = 1'b0;
            entry.data_view.data    = pwdata[7:0];
        end
    end

    assign fifo.push       = wr_access & push_addr & ~fifo.full;
    assign fifo.push_entry = entry;
    assign fifo.flush      = wr_access & (paddr == REG_CTRL) & pwdata[CTRL_BREAK_BIT];

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            case (paddr)
                REG_DATA, REG_MARK: pslverr = ~pwrite | fifo.full;  // Write only
                REG_CTRL: begin
                    if (!pwrite) begin
                        prdata[CTRL_ENABLE_BIT] = enable;
                    end
                end
                REG_STATUS: begin
                    if (pwrite) begin
                        pslverr = 1'b1;
                    end else begin
                        prdata[7:4] = fifo.level;
                        prdata[2]   = tx_end;
                        prdata[1]   = fifo.full;
                        prdata[0]   = fifo.empty;
                    end
                end
                default: pslverr = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            enable <= 1'b0;
        end else if (wr_access && paddr == REG_CTRL) begin
            enable <= pwdata[CTRL_ENABLE_BIT];
        end
    end

endmodule

// File: source/fm_encoder.sv
`timescale 1ns/1ps

module fm_encoder
    import fm_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        enable,
    output logic        fm_bit,
    output logic        fm_strobe,
    output logic        write_gate,
    output logic        tx_end,
    tx_fifo_if.pop_side fifo
);

    logic [HALF_CELL_W-1:0] timer;
    logic                   tick;
    tx_entry_u              head;
    logic [15:0]            head_pat;
    logic [15:0]            hold_pat;
    logic                   hold_empty;
    logic [14:0]            cur_sft;
    logic [3:0]             bit_cnt;    // Half-cells left in the shifter
    logic                   load_next;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            timer <= '0;
        end else if (!enable) begin
            timer <= '0;
        end else if (tick) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign tick = enable && (timer == HALF_CELL_W'(HALF_CELL_CLKS - 1));

    assign head = fifo.pop_entry;

    always_comb begin
        head_pat = '0;
        if (head.mark_view.is_mark) begin
            case (head.mark_view.sel)
                MARK_SEL_F8: head_pat = MARK_F8;
                MARK_SEL_FB: head_pat = MARK_FB;
                MARK_SEL_FC: head_pat = MARK_FC;
                MARK_SEL_FE: head_pat = MARK_FE;
            endcase
        end else begin
            for (int i = 0; i < 8; i++) begin
                head_pat[2*i+1] = 1'b1;             // Clock bit
                head_pat[2*i]   = head.data_view.data[i];
            end
        end
    end

    assign fifo.pop  = enable & hold_empty & ~fifo.empty & ~fifo.flush;
    assign load_next = tick && (bit_cnt == 4'd0) && !hold_empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_empty <= 1'b1;
        end else if (fifo.flush || load_next) begin
            hold_empty <= 1'b1;
        end else if (fifo.pop) begin
            hold_empty <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo.pop) begin
            hold_pat <= head_pat;
        end
        if (load_next) begin
            cur_sft <= hold_pat[14:0];
        end else if (tick && bit_cnt != 4'd0) begin
            cur_sft <= {cur_sft[13:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fm_bit     <= 1'b0;
            fm_strobe  <= 1'b0;
            write_gate <= 1'b0;
            tx_end     <= 1'b1;
            bit_cnt    <= '0;
        end else begin
            fm_bit    <= 1'b0;
            fm_strobe <= 1'b0;
            if (fifo.flush) begin
                write_gate <= 1'b0;
                bit_cnt    <= '0;
            end else if (tick) begin
                if (bit_cnt != 4'd0) begin
                    fm_bit    <= cur_sft[14];
                    fm_strobe <= 1'b1;
                    bit_cnt   <= bit_cnt - 1'b1;
                end else if (!hold_empty) begin
                    fm_bit     <= hold_pat[15];  // First half-cell straight out
                    fm_strobe  <= 1'b1;
                    bit_cnt    <= 4'd15;
                    write_gate <= 1'b1;
                    tx_end     <= 1'b0;
                end else begin
                    write_gate <= 1'b0;          // Nothing queued, stream ends
                    tx_end     <= 1'b1;
                end
            end
        end
    end

endmodule

// File: source/fdc_tx_top.sv
`timescale 1ns/1ps

module fdc_tx_top
    import fdc_regs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  fm_bit,
    output logic                  fm_strobe,
    output logic                  write_gate
);

    logic enable;
    logic tx_end;

    tx_fifo_if fifo_if ();

    fdc_apb_regs u_regs (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .tx_end  (tx_end),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .enable  (enable),
        .fifo    (fifo_if.push_side)
    );

    tx_fifo u_fifo (
        .clk  (clk),
        .rstn (rstn),
        .q    (fifo_if.fifo_side)
    );

    fm_encoder u_enc (
        .clk        (clk),
        .rstn       (rstn),
        .enable     (enable),
        .fm_bit     (fm_bit),
        .fm_strobe  (fm_strobe),
        .write_gate (write_gate),
        .tx_end     (tx_end),
        .fifo       (fifo_if.pop_side)
    );

endmodule

// File: tests/fdc_tx_properties.sv
`timescale 1ns/1ps

module fdc_tx_properties (
    input logic clk,
    input logic rstn,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic fm_bit,
    input logic fm_strobe,
    input logic write_gate,
    input logic flush
);

    int fail_count = 0;

    strobe_in_gate: assert property (@(posedge clk) disable iff (!rstn)
        fm_strobe |-> write_gate)
        else begin
            $error("fm_strobe seen while write_gate is low");
            fail_count++;
        end

    bit_needs_strobe: assert property (@(posedge clk) disable iff (!rstn)
        fm_bit |-> fm_strobe)
        else begin
            $error("fm_bit high without fm_strobe");
            fail_count++;
        end

    ready_in_access: assert property (@(posedge clk) disable iff (!rstn)
        (psel && penable) |-> pready)
        else begin
            $error("pready low in an APB access phase");
            fail_count++;
        end

    flush_drops_gate: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> !write_gate)
        else begin
            $error("write_gate still high one cycle after flush");
            fail_count++;
        end

endmodule

bind fm_encoder fdc_tx_properties u_enc_props (
    .clk        (clk),
    .rstn       (rstn),
    .psel       (1'b0),
    .penable    (1'b0),
    .pready     (1'b1),
    .fm_bit     (fm_bit),
    .fm_strobe  (fm_strobe),
    .write_gate (write_gate),
    .flush      (fifo.flush)
);

bind fdc_apb_regs fdc_tx_properties u_apb_props (
    .clk        (clk),
    .rstn       (rstn),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .fm_bit     (1'b0),
    .fm_strobe  (1'b0),
    .write_gate (1'b0),
    .flush      (1'b0)
);

// File: tests/fdc_tx_tb.sv
`timescale 1ns/1ps

module fdc_tx_tb
    import fm_pkg::*;
    import fdc_regs_pkg::*;
();

    localparam int NUM_ENTRIES  = 8;
    localparam int TIMEOUT_CLKS = 2000;
    localparam logic [15:0] MARK_PATS [4] = '{MARK_F8, MARK_FB, MARK_FC, MARK_FE};
    localparam logic [1:0]  MARK_SELS [4] = '{MARK_SEL_F8, MARK_SEL_FB, MARK_SEL_FC, MARK_SEL_FE};

    logic                  clk;
    logic                  rstn;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  fm_bit;
    logic                  fm_strobe;
    logic                  write_gate;

    logic        tbl_mark   [NUM_ENTRIES];  // Stimulus table
    logic [7:0]  tbl_value  [NUM_ENTRIES];
    logic [15:0] tbl_expect [NUM_ENTRIES];

    logic [15:0] got_q [$];                 // Collected 16 half-cell groups
    logic [15:0] shift_word = '0;
    int          bit_num = 0;
    int          strobe_cnt = 0;
    int          gate_rises = 0;
    logic        gate_prev = 1'b0;
    int          err_cnt = 0;
    int          fail_cnt = 0;

    fdc_tx_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Serial stream collector, sampled away from the rising edge
    always @(negedge clk) begin
        if (fm_strobe) strobe_cnt++;
        if (write_gate && !gate_prev) gate_rises++;
        gate_prev = write_gate;
        if (!write_gate) begin
            bit_num = 0;                    // Partial group is dropped
        end else if (fm_strobe) begin
            shift_word = {shift_word[14:0], fm_bit};
            bit_num++;
            if (bit_num == 16) begin
                got_q.push_back(shift_word);
                bit_num = 0;
            end
        end
    end

    // Clock 1 before every data bit, MSB first
    function automatic logic [15:0] fm_data_cells(input logic [7:0] d);
        logic [15:0] p;
        p = '0;
        for (int i = 7; i >= 0; i--) p = {p[13:0], 1'b1, d[i]};
        return p;
    endfunction

    function automatic logic [31:0] status_word(input int level, input logic tx_end,
                                                input logic full, input logic empty);
        return {24'h0, 4'(level), 1'b0, tx_end, full, empty};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("ERR t=%0t %s expected=%h got=%h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int t;
        @(posedge clk);
        #5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #5 penable = 1'b1;
        #10;
        t = 0;
        while (!pready && t < 16) begin
            @(posedge clk);
            #15 t++;
        end
        if (!pready) begin
            $display("APB slave never raised pready at offset %h", addr);
            fail_cnt++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic push_entry(input int idx, output logic err);
        apb_write(tbl_mark[idx] ? REG_MARK : REG_DATA, {24'h0, tbl_value[idx]}, err);
    endtask

    task automatic wait_groups(input int n);
        int t;
        t = 0;
        while (got_q.size() < n && t < TIMEOUT_CLKS) begin
            @(posedge clk);
            t++;
        end
        if (got_q.size() < n) begin
            $display("Timed out waiting for %0d FM groups, only %0d arrived", n, got_q.size());
            fail_cnt++;
        end
    endtask

    task automatic wait_gate(input logic level);
        int t;
        t = 0;
        while (write_gate !== level && t < TIMEOUT_CLKS) begin
            @(posedge clk);
            t++;
        end
        if (write_gate !== level) begin
            $display("Timed out waiting for write_gate to become %b", level);
            fail_cnt++;
        end
    endtask

    initial begin
        logic        err;
        logic [31:0] rd;
        int          base_rises;
        int          base_strobes;
        int          assert_cnt;
        void'($urandom(32'he3ef));
        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        tbl_value[0] = 8'h00;
        tbl_value[1] = 8'hFF;
        tbl_value[2] = 8'($urandom);
        tbl_value[3] = 8'($urandom);
        for (int i = 0; i < 4; i++) begin
            tbl_mark[i]     = 1'b0;
            tbl_expect[i]   = fm_data_cells(tbl_value[i]);
            tbl_mark[4+i]   = 1'b1;
            tbl_value[4+i]  = {6'h0, MARK_SELS[i]};
            tbl_expect[4+i] = MARK_PATS[i];
        end
        repeat (3) @(posedge clk);
        #5 rstn = 1'b1;

        // Data bytes and marks, one entry at a time
        apb_write(REG_CTRL, 32'h1, err);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            push_entry(i, err);
            check_value("pslverr", err, 0);
            wait_groups(1);
            if (got_q.size() > 0) check_value("fm_pattern", got_q.pop_front(), tbl_expect[i]);
        end
        wait_gate(1'b0);

        // Queued while disabled, then streamed back to back
        apb_write(REG_CTRL, 32'h0, err);
        for (int i = 0; i < NUM_ENTRIES; i++) push_entry(i, err);
        base_rises = gate_rises;
        apb_write(REG_CTRL, 32'h1, err);
        wait_groups(NUM_ENTRIES);
        wait_gate(1'b0);
        check_value("write_gate_rises", gate_rises - base_rises, 1);
        for (int i = 0; i < NUM_ENTRIES && got_q.size() > 0; i++) begin
            check_value("fm_pattern", got_q.pop_front(), tbl_expect[i]);
        end
        apb_read(REG_STATUS, rd, err);
        check_value("status", rd, status_word(0, 1'b1, 1'b0, 1'b1));

        // Fill while disabled
        apb_write(REG_CTRL, 32'h0, err);
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            apb_write(REG_DATA, 32'(i), err);
            check_value("pslverr", err, i == FIFO_DEPTH);
        end
        apb_read(REG_STATUS, rd, err);
        check_value("status", rd, status_word(FIFO_DEPTH, 1'b1, 1'b1, 1'b0));
        apb_write(REG_CTRL, 32'h2, err);

        // Break in the middle of a stream
        apb_write(REG_CTRL, 32'h1, err);
        for (int i = 0; i < 4; i++) apb_write(REG_DATA, 32'($urandom & 8'hFF), err);
        wait_groups(1);
        apb_write(REG_CTRL, 32'h3, err);
        check_value("write_gate", write_gate, 0);
        base_strobes = strobe_cnt;
        repeat (64 * HALF_CELL_CLKS) @(posedge clk);
        check_value("fm_strobe_count", strobe_cnt - base_strobes, 0);
        apb_read(REG_STATUS, rd, err);
        check_value("status", rd, status_word(0, 1'b1, 1'b0, 1'b1));

        // Error responses and control readback
        apb_read(4'h2, rd, err);
        check_value("pslverr", err, 1);
        apb_write(4'h6, 32'h0, err);
        check_value("pslverr", err, 1);
        apb_write(REG_STATUS, 32'h0, err);
        check_value("pslverr", err, 1);
        apb_read(REG_DATA, rd, err);
        check_value("pslverr", err, 1);
        apb_read(REG_CTRL, rd, err);
        check_value("pslverr", err, 0);
        check_value("prdata", rd, 32'h1);

        assert_cnt = uut.u_enc.u_enc_props.fail_count + uut.u_regs.u_apb_props.fail_count;
        $display("Value errors: %0d, other failures: %0d, assertion failures: %0d",
                 err_cnt, fail_cnt, assert_cnt);
        if (err_cnt == 0 && fail_cnt == 0 && assert_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: fdc_tx_top.f
source/fm_pkg.sv
source/fdc_regs_pkg.sv
source/tx_fifo_if.sv
source/tx_fifo.sv
source/fdc_apb_regs.sv
source/fm_encoder.sv
source/fdc_tx_top.sv
tests/fdc_tx_properties.sv
tests/fdc_tx_tb.sv

// File: Bender.yml
package:
  name: fdc_tx

sources:
  - files:
      - source/fm_pkg.sv
      - source/fdc_regs_pkg.sv
      - source/tx_fifo_if.sv
      - source/tx_fifo.sv
      - source/fdc_apb_regs.sv
      - source/fm_encoder.sv
      - source/fdc_tx_top.sv
  - target: test
    files:
      - tests/fdc_tx_properties.sv
      - tests/fdc_tx_tb.sv
